// File: hdl/ecl_params.svh
`ifndef ECL_PARAMS_SVH
`define ECL_PARAMS_SVH

// data path and address widths
`define GRLEN       32
`define REG_ADDR_W  5
`define CSR_ADDR_W  14
`define ALU_CODE_W  4

// instruction field positions
`define INST_RD_LSB   0
`define INST_RJ_LSB   5
`define INST_RK_LSB   10
`define INST_CSR_LSB  10

`endif

// File: hdl/ecl_pkg.sv
`include "ecl_params.svh"

`default_nettype none

package ecl_pkg;

   typedef logic [`GRLEN-1:0]      word_t;
   typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
   typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;

   // opaque to the ECL, the ALU decodes it
   typedef logic [`ALU_CODE_W-1:0] alu_code_t;

   // predecoded operation from the fetch stage
   typedef struct packed {
      logic      csr_related;
      logic      csr_write;
      logic      csr_xchg;
      logic      rd_to_rj;
      logic      rd_read;
      logic      pc_related;
      logic      imm_used;
      alu_code_t alu_code;
   } decode_op_t;

endpackage

`default_nettype wire

// File: hdl/ecl_decode.sv
`include "ecl_params.svh"

`default_nettype none

module ecl_decode (
   input  wire logic               valid_d,
   input  wire logic [31:0]        inst_d,
   input  ecl_pkg::word_t          pc_d,
   input  ecl_pkg::decode_op_t     op_d,
   input  ecl_pkg::word_t          imm_d,
   input  ecl_pkg::word_t          rs1_data_d,
   input  ecl_pkg::word_t          rs2_data_d,
   input  wire logic               rf_wen_d,
   output ecl_pkg::reg_addr_t      rs1_d,
   output ecl_pkg::reg_addr_t      rs2_d,
   output logic                    alu_go_d,
   output logic                    csr_go_d,
   output logic                    alu_wen_d,
   output logic                    csr_rdwen_d,
   output logic                    csr_wen_d,
   output logic                    csr_xchg_d,
   output logic                    imm_used_d,
   output ecl_pkg::word_t          opa_d,
   output ecl_pkg::word_t          opb_d,
   output ecl_pkg::alu_code_t      alu_op_d,
   output ecl_pkg::csr_addr_t      csr_raddr_d
);
   import ecl_pkg::*;

   reg_addr_t rd_fld;
   reg_addr_t rj_fld;
   reg_addr_t rk_fld;

   ///////////////////////////////////////////////////////////////////////
   // dispatch, exactly one lane per valid instruction
   assign csr_go_d = valid_d & op_d.csr_related;
   assign alu_go_d = valid_d & ~op_d.csr_related;

   assign alu_wen_d   = rf_wen_d & alu_go_d;
   assign csr_rdwen_d = rf_wen_d & csr_go_d;
   assign csr_wen_d   = (op_d.csr_write | op_d.csr_xchg) & csr_go_d;
   assign csr_xchg_d  = op_d.csr_xchg & csr_go_d;

   ///////////////////////////////////////////////////////////////////////
   // register and csr addresses
   assign rd_fld = inst_d[`INST_RD_LSB +: `REG_ADDR_W];
   assign rj_fld = inst_d[`INST_RJ_LSB +: `REG_ADDR_W];
   assign rk_fld = inst_d[`INST_RK_LSB +: `REG_ADDR_W];

   // pc operand reads r0 so nothing is forwarded onto it
   assign rs1_d = op_d.pc_related ? '0 : (op_d.rd_to_rj ? rd_fld : rj_fld);
   assign rs2_d = op_d.rd_read ? rd_fld : rk_fld;

   assign csr_raddr_d = inst_d[`INST_CSR_LSB +: `CSR_ADDR_W];

   // operand pre-selection
   assign imm_used_d = op_d.imm_used & alu_go_d;
   assign opa_d      = op_d.pc_related ? pc_d : rs1_data_d;
   assign opb_d      = imm_used_d ? imm_d : rs2_data_d;
   assign alu_op_d   = op_d.alu_code;

endmodule

`default_nettype wire

// File: hdl/alu_lane.sv
`default_nettype none

module alu_lane (
   input  wire logic               clk,
   input  wire logic               rst_n,
   input  wire logic               alu_go_d,
   input  wire logic               alu_wen_d,
   input  wire logic               imm_used_d,
   input  ecl_pkg::reg_addr_t      rs1_d,
   input  ecl_pkg::reg_addr_t      rs2_d,
   input  ecl_pkg::word_t          opa_d,
   input  ecl_pkg::word_t          opb_d,
   input  ecl_pkg::alu_code_t      alu_op_d,
   input  ecl_pkg::word_t          alu_res_e,
   input  ecl_pkg::reg_addr_t      rd_m,
   input  ecl_pkg::reg_addr_t      rd_w,
   input  wire logic               wen_m,
   input  wire logic               wen_w,
   input  ecl_pkg::word_t          rd_data_m,
   input  ecl_pkg::word_t          rd_data_w,
   output ecl_pkg::word_t          alu_a_e,
   output ecl_pkg::word_t          alu_b_e,
   output ecl_pkg::alu_code_t      alu_op_e,
   output ecl_pkg::word_t          alu_res_m,
   output logic                    alu_wen_m
);
   import ecl_pkg::*;

   reg_addr_t rs1_e;
   reg_addr_t rs2_e;
   word_t     opa_e;
   word_t     opb_e;
   logic      imm_used_e;
   logic      alu_valid_e;
   logic      alu_wen_e;
   logic      fwd_a_m;
   logic      fwd_a_w;
   logic      fwd_b_m;
   logic      fwd_b_w;

   ///////////////////////////////////////////////////////////////////////
   // d to e
   always_ff @(posedge clk) begin
      rs1_e      <= rs1_d;
      rs2_e      <= rs2_d;
      opa_e      <= opa_d;
      opb_e      <= opb_d;
      alu_op_e   <= alu_op_d;
      imm_used_e <= imm_used_d;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         alu_valid_e <= 1'b0;
         alu_wen_e   <= 1'b0;
      end else begin
         alu_valid_e <= alu_go_d;
         alu_wen_e   <= alu_wen_d;
      end
   end

   ///////////////////////////////////////////////////////////////////////
   // forwarding, m wins over w, r0 never matches
   assign fwd_a_m = wen_m && (rd_m != '0) && (rd_m == rs1_e);
   assign fwd_a_w = wen_w && (rd_w != '0) && (rd_w == rs1_e);
   assign fwd_b_m = !imm_used_e && wen_m && (rd_m != '0) && (rd_m == rs2_e);
   assign fwd_b_w = !imm_used_e && wen_w && (rd_w != '0) && (rd_w == rs2_e);

   // operands also feed the csr write data
   assign alu_a_e = fwd_a_m ? rd_data_m : (fwd_a_w ? rd_data_w : opa_e);
   assign alu_b_e = fwd_b_m ? rd_data_m : (fwd_b_w ? rd_data_w : opb_e);

   ///////////////////////////////////////////////////////////////////////
   // e to m
   always_ff @(posedge clk) begin
      if (alu_valid_e) begin
         alu_res_m <= alu_res_e;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         alu_wen_m <= 1'b0;
      end else begin
         alu_wen_m <= alu_wen_e;
      end
   end

endmodule

`default_nettype wire

// File: hdl/csr_lane.sv
`default_nettype none

module csr_lane (
   input  wire logic               clk,
   input  wire logic               rst_n,
   input  wire logic               csr_go_d,
   input  wire logic               csr_rdwen_d,
   input  wire logic               csr_wen_d,
   input  wire logic               csr_xchg_d,
   input  ecl_pkg::csr_addr_t      csr_raddr_d,
   input  ecl_pkg::word_t          csr_rdata_d,
   input  ecl_pkg::word_t          alu_a_e,
   input  ecl_pkg::word_t          alu_b_e,
   output ecl_pkg::word_t          csr_rdata_m,
   output logic                    csr_valid_m,
   output logic                    csr_rdwen_m,
   output ecl_pkg::csr_addr_t      csr_waddr_m,
   output ecl_pkg::word_t          csr_wdata_m,
   output logic                    csr_wen_m,
   output logic                    stall_req
);
   import ecl_pkg::*;

   word_t     csr_rdata_e;
   csr_addr_t csr_waddr_e;
   logic      csr_xchg_e;
   logic      csr_valid_e;
   logic      csr_rdwen_e;
   logic      csr_wen_e;

   // read data and write address, d to m
   always_ff @(posedge clk) begin
      csr_rdata_e <= csr_rdata_d;
      csr_rdata_m <= csr_rdata_e;
      csr_waddr_e <= csr_raddr_d;
      csr_waddr_m <= csr_waddr_e;
      csr_xchg_e  <= csr_xchg_d;
   end

   // exchange masks the old rd value with rj
   always_ff @(posedge clk) begin
      csr_wdata_m <= csr_xchg_e ? (alu_a_e & alu_b_e) : alu_b_e;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         csr_valid_e <= 1'b0;
         csr_valid_m <= 1'b0;
         csr_rdwen_e <= 1'b0;
         csr_rdwen_m <= 1'b0;
         csr_wen_e   <= 1'b0;
         csr_wen_m   <= 1'b0;
      end else begin
         csr_valid_e <= csr_go_d;
         csr_valid_m <= csr_valid_e;
         csr_rdwen_e <= csr_rdwen_d;
         csr_rdwen_m <= csr_rdwen_e;
         csr_wen_e   <= csr_wen_d;
         csr_wen_m   <= csr_wen_e;
      end
   end

   ///////////////////////////////////////////////////////////////////////
   // fetch stall, set at decode, dropped once the write leaves e
   assign stall_req = csr_wen_d | csr_wen_e;

endmodule

`default_nettype wire

// File: hdl/rd_writeback.sv
`default_nettype none

module rd_writeback (
   input  wire logic               clk,
   input  wire logic               rst_n,
   input  ecl_pkg::reg_addr_t      rf_target_d,
   input  ecl_pkg::word_t          alu_res_m,
   input  wire logic               alu_wen_m,
   input  ecl_pkg::word_t          csr_rdata_m,
   input  wire logic               csr_valid_m,
   input  wire logic               csr_rdwen_m,
   output ecl_pkg::reg_addr_t      rd_m,
   output logic                    wen_m,
   output ecl_pkg::word_t          rd_data_m,
   output ecl_pkg::reg_addr_t      rd_w,
   output logic                    wen_w,
   output ecl_pkg::word_t          rd_data_w
);
   import ecl_pkg::*;

   reg_addr_t rd_e;

   // both lanes share one destination pipe
   always_ff @(posedge clk) begin
      rd_e <= rf_target_d;
      rd_m <= rd_e;
   end

   ///////////////////////////////////////////////////////////////////////
   // stage m merge
   assign wen_m     = alu_wen_m | csr_rdwen_m;
   assign rd_data_m = csr_valid_m ? csr_rdata_m : alu_res_m;

   // m to w
   always_ff @(posedge clk) begin
      rd_w      <= rd_m;
      rd_data_w <= rd_data_m;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wen_w <= 1'b0;
      end else begin
         wen_w <= wen_m;
      end
   end

endmodule

`default_nettype wire

// File: hdl/exu_ecl.sv
`default_nettype none

module exu_ecl (
   input  wire logic               clk,
   input  wire logic               rst_n,
   // fetch stage
   input  wire logic               valid_d,
   input  wire logic [31:0]        inst_d,
   input  ecl_pkg::word_t          pc_d,
   input  ecl_pkg::decode_op_t     op_d,
   input  ecl_pkg::word_t          imm_d,
   input  wire logic               rf_wen_d,
   input  ecl_pkg::reg_addr_t      rf_target_d,
   // register file read
   output ecl_pkg::reg_addr_t      rs1_d,
   output ecl_pkg::reg_addr_t      rs2_d,
   input  ecl_pkg::word_t          rs1_data_d,
   input  ecl_pkg::word_t          rs2_data_d,
   // csr file
   output ecl_pkg::csr_addr_t      csr_raddr_d,
   input  ecl_pkg::word_t          csr_rdata_d,
   output ecl_pkg::csr_addr_t      csr_waddr_m,
   output ecl_pkg::word_t          csr_wdata_m,
   output logic                    csr_wen_m,
   output logic                    stall_req,
   // alu
   output ecl_pkg::word_t          alu_a_e,
   output ecl_pkg::word_t          alu_b_e,
   output ecl_pkg::alu_code_t      alu_op_e,
   input  ecl_pkg::word_t          alu_res_e,
   // register file write
   output ecl_pkg::reg_addr_t      rd_w,
   output logic                    wen_w,
   output ecl_pkg::word_t          rd_data_w
);
   import ecl_pkg::*;

   logic      alu_go_d, csr_go_d, alu_wen_d, csr_rdwen_d, csr_wen_d, csr_xchg_d;
   logic      imm_used_d;
   word_t     opa_d, opb_d;
   alu_code_t alu_op_d;
   word_t     alu_res_m, csr_rdata_m, rd_data_m;
   logic      alu_wen_m, csr_valid_m, csr_rdwen_m, wen_m;
   reg_addr_t rd_m;

   ecl_decode u_decode (
      .valid_d, .inst_d, .pc_d, .op_d, .imm_d, .rs1_data_d, .rs2_data_d, .rf_wen_d,
      .rs1_d, .rs2_d, .alu_go_d, .csr_go_d, .alu_wen_d, .csr_rdwen_d, .csr_wen_d,
      .csr_xchg_d, .imm_used_d, .opa_d, .opb_d, .alu_op_d, .csr_raddr_d
   );

   alu_lane u_alu_lane (
      .clk, .rst_n, .alu_go_d, .alu_wen_d, .imm_used_d, .rs1_d, .rs2_d, .opa_d, .opb_d,
      .alu_op_d, .alu_res_e, .rd_m, .rd_w, .wen_m, .wen_w, .rd_data_m, .rd_data_w,
      .alu_a_e, .alu_b_e, .alu_op_e, .alu_res_m, .alu_wen_m
   );

   csr_lane u_csr_lane (
      .clk, .rst_n, .csr_go_d, .csr_rdwen_d, .csr_wen_d, .csr_xchg_d, .csr_raddr_d,
      .csr_rdata_d, .alu_a_e, .alu_b_e, .csr_rdata_m, .csr_valid_m, .csr_rdwen_m,
      .csr_waddr_m, .csr_wdata_m, .csr_wen_m, .stall_req
   );

   rd_writeback u_rd_writeback (
      .clk, .rst_n, .rf_target_d, .alu_res_m, .alu_wen_m, .csr_rdata_m, .csr_valid_m,
      .csr_rdwen_m, .rd_m, .wen_m, .rd_data_m, .rd_w, .wen_w, .rd_data_w
   );

endmodule

`default_nettype wire

// File: test/tb_exu_ecl.sv
`default_nettype none

module tb_exu_ecl;
   timeunit 1ns;
   timeprecision 100ps;

   import ecl_pkg::*;

   localparam int CLK_PERIOD   = 8;
   localparam int RESET_CYCLES = 16;
   // instructions issued over all tests
   localparam int TOTAL_INSTR  = 21;

   logic          clk = 1'b0;
   logic          rst_n;
   logic          valid_d;
   logic [31:0]   inst_d;
   word_t         pc_d;
   decode_op_t    op_d;
   word_t         imm_d;
   logic          rf_wen_d;
   reg_addr_t     rf_target_d;
   reg_addr_t     rs1_d;
   reg_addr_t     rs2_d;
   word_t         rs1_data_d;
   word_t         rs2_data_d;
   csr_addr_t     csr_raddr_d;
   word_t         csr_rdata_d;
   csr_addr_t     csr_waddr_m;
   word_t         csr_wdata_m;
   logic          csr_wen_m;
   logic          stall_req;
   word_t         alu_a_e;
   word_t         alu_b_e;
   alu_code_t     alu_op_e;
   word_t         alu_res_e;
   reg_addr_t     rd_w;
   logic          wen_w;
   word_t         rd_data_w;

   word_t         rf [32];
   word_t         arch [32];
   word_t         csr_mem [16384];
   word_t         csr_ref [16384];
   int            cyc = 0;
   int            error_count = 0;
   string         cur_test = "none";
   logic          csr_wr_ok = 1'b0;
   word_t         last_wdata;
   reg_addr_t     exp_rd [$];
   word_t         exp_data [$];
   int            exp_cyc [$];

   exu_ecl DUT (.*);

   always #(CLK_PERIOD / 2) clk = ~clk;

   ///////////////////////////////////////////////////////////////////////
   // models: alu, register file with write-through, csr array
   function automatic word_t alu_calc(input alu_code_t code, input word_t a, input word_t b);
      case (code)
         4'd0:    return a + b;
         4'd1:    return a - b;
         4'd2:    return a & b;
         4'd3:    return a | b;
         4'd4:    return a ^ b;
         default: return '0;
      endcase
   endfunction

   assign alu_res_e   = alu_calc(alu_op_e, alu_a_e, alu_b_e);
   assign rs1_data_d  = (rs1_d == '0) ? '0 :
                        ((wen_w && rd_w == rs1_d) ? rd_data_w : rf[rs1_d]);
   assign rs2_data_d  = (rs2_d == '0) ? '0 :
                        ((wen_w && rd_w == rs2_d) ? rd_data_w : rf[rs2_d]);
   assign csr_rdata_d = csr_mem[csr_raddr_d];

   always @(posedge clk) begin
      cyc <= cyc + 1;
      if (wen_w && rd_w != '0) begin
         rf[rd_w] <= rd_data_w;
      end
      if (csr_wen_m) begin
         csr_mem[csr_waddr_m] <= csr_wdata_m;
      end
   end

   ///////////////////////////////////////////////////////////////////////
   // reporting
   task automatic stop_on_error(input string msg);
      error_count++;
      $display("%s", msg);
      $display("Finished with errors");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check_value(input string what, input word_t expected, input word_t actual);
      if (actual !== expected) begin
         stop_on_error($sformatf("mismatch %s %s expected %h actual %h",
                                 cur_test, what, expected, actual));
      end
   endtask

   // writeback monitor, results leave in program order
   always @(negedge clk) begin
      reg_addr_t e_rd;
      word_t     e_data;
      int        e_cyc;
      if (rst_n && csr_wen_m && !csr_wr_ok) begin
         stop_on_error($sformatf("%s: CSR write seen where none was issued", cur_test));
      end else if (rst_n && wen_w) begin
         if (exp_rd.size() == 0) begin
            stop_on_error($sformatf("%s: register write with none pending", cur_test));
         end else begin
            e_rd   = exp_rd.pop_front();
            e_data = exp_data.pop_front();
            e_cyc  = exp_cyc.pop_front();
            check_value("wb cycle", 32'(e_cyc), 32'(cyc));
            check_value("rd_w", 32'(e_rd), 32'(rd_w));
            check_value("rd_data_w", e_data, rd_data_w);
         end
      end
   end

   ///////////////////////////////////////////////////////////////////////
   // stimulus helpers
   function automatic decode_op_t make_op(input logic csr, input logic wr, input logic xchg,
                                          input logic pc, input logic imm, input logic rd_rd,
                                          input alu_code_t code);
      decode_op_t op;
      op             = '0;
      op.csr_related = csr;
      op.csr_write   = wr;
      op.csr_xchg    = xchg;
      op.pc_related  = pc;
      op.imm_used    = imm;
      op.rd_read     = rd_rd;
      op.alu_code    = code;
      return op;
   endfunction

   function automatic logic [31:0] make_inst(input logic [13:0] hi, input reg_addr_t rj,
                                             input reg_addr_t rd);
      return {8'h00, hi, rj, rd};
   endfunction

   // drive one instruction and record the expected writeback
   task automatic issue(input decode_op_t op, input logic [31:0] inst, input word_t pc,
                        input word_t imm, input logic wen);
      reg_addr_t rd;
      reg_addr_t rj;
      reg_addr_t rk;
      csr_addr_t csr;
      word_t     a;
      word_t     b;
      word_t     res;
      rd  = inst[4:0];
      rj  = inst[9:5];
      rk  = inst[14:10];
      csr = inst[23:10];
      @(posedge clk);
      valid_d     <= 1'b1;
      inst_d      <= inst;
      pc_d        <= pc;
      op_d        <= op;
      imm_d       <= imm;
      rf_wen_d    <= wen;
      rf_target_d <= rd;
      if (op.csr_related) begin
         res = csr_ref[csr];
         if (op.csr_write || op.csr_xchg) begin
            a          = arch[rj];
            b          = arch[rd];
            last_wdata = op.csr_xchg ? (a & b) : b;
            csr_ref[csr] = last_wdata;
         end
      end else begin
         a   = op.pc_related ? pc : arch[rj];
         b   = op.imm_used ? imm : arch[rk];
         res = alu_calc(op.alu_code, a, b);
      end
      if (wen) begin
         exp_rd.push_back(rd);
         exp_data.push_back(res);
         // cyc still holds the cycle before d here
         exp_cyc.push_back(cyc + 4);
         if (rd != '0) begin
            arch[rd] = res;
         end
      end
   endtask

   task automatic bubble();
      @(posedge clk);
      valid_d  <= 1'b0;
      op_d     <= '0;
      rf_wen_d <= 1'b0;
   endtask

   task automatic drain();
      int n;
      n = 0;
      while (exp_rd.size() != 0 && n < 12) begin
         bubble();
         n++;
      end
      if (exp_rd.size() != 0) begin
         stop_on_error($sformatf("%s: writeback never arrived", cur_test));
      end
   endtask

   ///////////////////////////////////////////////////////////////////////
   // directed tests
   task automatic test_reset();
      cur_test = "reset";
      repeat (RESET_CYCLES) begin
         @(negedge clk);
         check_value("wen_w", 32'h0, 32'(wen_w));
         check_value("csr_wen_m", 32'h0, 32'(csr_wen_m));
         check_value("stall_req", 32'h0, 32'(stall_req));
      end
      @(posedge clk);
      rst_n <= 1'b1;
   endtask

   task automatic test_alu_regs();
      alu_code_t code;
      reg_addr_t rj;
      reg_addr_t rk;
      cur_test = "alu_regs";
      for (int i = 0; i < 8; i++) begin
         code = alu_code_t'($urandom % 5);
         rj   = reg_addr_t'(1 + $urandom % 4);
         rk   = reg_addr_t'(1 + $urandom % 4);
         issue(make_op(0, 0, 0, 0, 0, 0, code), make_inst({9'h0, rk}, rj, reg_addr_t'(10 + i)),
               '0, '0, 1'b1);
      end
      drain();
   endtask

   task automatic test_imm_pc();
      word_t pc;
      word_t imm;
      word_t a_exp;
      cur_test = "imm_pc";
      pc  = $urandom;
      imm = $urandom;
      issue(make_op(0, 0, 0, 1, 1, 0, 4'd0), make_inst(14'h0, 5'd3, 5'd20), pc, imm, 1'b1);
      bubble();
      @(negedge clk);
      check_value("alu_a_e", pc, alu_a_e);
      check_value("alu_b_e", imm, alu_b_e);
      imm   = $urandom;
      a_exp = arch[2];
      // rk names r20 while it sits in w, the immediate still wins
      issue(make_op(0, 0, 0, 0, 1, 0, 4'd4), make_inst({9'h0, 5'd20}, 5'd2, 5'd21), pc, imm,
            1'b1);
      bubble();
      @(negedge clk);
      check_value("alu_a_e", a_exp, alu_a_e);
      check_value("alu_b_e", imm, alu_b_e);
      drain();
   endtask

   task automatic test_forwarding();
      cur_test = "forwarding";
      issue(make_op(0, 0, 0, 0, 0, 0, 4'd0), make_inst({9'h0, 5'd2}, 5'd1, 5'd7), '0, '0, 1);
      // distance 1 from m
      issue(make_op(0, 0, 0, 0, 0, 0, 4'd1), make_inst({9'h0, 5'd3}, 5'd7, 5'd7), '0, '0, 1);
      // r7 in both m and w, m wins
      issue(make_op(0, 0, 0, 0, 0, 0, 4'd3), make_inst({9'h0, 5'd7}, 5'd1, 5'd9), '0, '0, 1);
      // r9 from m, r7 at distance 2 from w
      issue(make_op(0, 0, 0, 0, 0, 0, 4'd4), make_inst({9'h0, 5'd7}, 5'd9, 5'd10), '0, '0, 1);
      // r0 written with a nonzero sum but still reads zero
      issue(make_op(0, 0, 0, 0, 0, 0, 4'd0), make_inst({9'h0, 5'd2}, 5'd1, 5'd0), '0, '0, 1);
      issue(make_op(0, 0, 0, 0, 0, 0, 4'd0), make_inst({9'h0, 5'd3}, 5'd0, 5'd12), '0, '0, 1);
      drain();
   endtask

   task automatic test_csr_read();
      cur_test = "csr_read";
      issue(make_op(1, 0, 0, 0, 0, 0, 4'd0), make_inst(14'h0005, 5'd0, 5'd22), '0, '0, 1);
      issue(make_op(1, 0, 0, 0, 0, 0, 4'd0), make_inst(14'h2a31, 5'd0, 5'd23), '0, '0, 1);
      drain();
   endtask

   // csr write with the stall pattern over d, e and m
   task automatic run_csr_write(input decode_op_t op, input logic [31:0] inst);
      issue(op, inst, '0, '0, 1'b1);
      @(negedge clk);
      check_value("stall_req in d", 32'h1, 32'(stall_req));
      bubble();
      @(negedge clk);
      check_value("stall_req in e", 32'h1, 32'(stall_req));
      check_value("csr_wen_m in e", 32'h0, 32'(csr_wen_m));
      bubble();
      csr_wr_ok = 1'b1;
      @(negedge clk);
      check_value("csr_wen_m", 32'h1, 32'(csr_wen_m));
      check_value("stall_req in m", 32'h0, 32'(stall_req));
      check_value("csr_waddr_m", 32'(inst[23:10]), 32'(csr_waddr_m));
      check_value("csr_wdata_m", last_wdata, csr_wdata_m);
      bubble();
      csr_wr_ok = 1'b0;
   endtask

   task automatic test_csr_write();
      cur_test = "csr_write";
      issue(make_op(0, 0, 0, 0, 0, 0, 4'd4), make_inst({9'h0, 5'd2}, 5'd1, 5'd5), '0, '0, 1);
      // rd operand comes forwarded from m
      run_csr_write(make_op(1, 1, 0, 0, 0, 1, 4'd0), make_inst(14'h0100, 5'd0, 5'd5));
      run_csr_write(make_op(1, 0, 1, 0, 0, 1, 4'd0), make_inst(14'h0100, 5'd5, 5'd6));
      drain();
   endtask

   ///////////////////////////////////////////////////////////////////////
   initial begin
      #(TOTAL_INSTR * 10 * CLK_PERIOD);
      stop_on_error("timeout: the tests did not finish in time");
   end

   initial begin
      void'($urandom(71919));
      rst_n       = 1'b0;
      valid_d     = 1'b0;
      inst_d      = '0;
      pc_d        = '0;
      op_d        = '0;
      imm_d       = '0;
      rf_wen_d    = 1'b0;
      rf_target_d = '0;
      for (int i = 0; i < 32; i++) begin
         rf[i]   = (i == 0) ? '0 : 32'h1000_0000 + word_t'(i) * 32'h0101_0101;
         arch[i] = rf[i];
      end
      for (int i = 0; i < 16384; i++) begin
         csr_mem[i] = (word_t'(i) * 32'h9e37_79b1) ^ 32'h5a5a_0000;
         csr_ref[i] = csr_mem[i];
      end
      test_reset();
      test_alu_regs();
      test_imm_pc();
      test_forwarding();
      test_csr_read();
      test_csr_write();
      repeat (4) bubble();
      if (error_count == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: compile.f
+incdir+hdl
hdl/ecl_pkg.sv
hdl/ecl_decode.sv
hdl/alu_lane.sv
hdl/csr_lane.sv
hdl/rd_writeback.sv
hdl/exu_ecl.sv
test/tb_exu_ecl.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f compile.f \
   --top-module tb_exu_ecl -o tb_exu_ecl
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/tb_exu_ecl 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "Finished with no errors"; then
   exit 0
fi
exit 1
